/* sources.f */
c64_loader_pkg.sv
prg_stream_parser.sv
basic_ptr_init.sv
mem_write_slot.sv
key_autotype.sv
prg_loader_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_prg_loader.sv

/* Bender.yml */
package:
  name: prg_loader

sources:
  - c64_loader_pkg.sv
  - prg_stream_parser.sv
  - basic_ptr_init.sv
  - mem_write_slot.sv
  - key_autotype.sv
  - prg_loader_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_checker.sv
      - tb_prg_loader.sv

/* tb_prg_loader.sv */
// Testbench top with random PRG downloads, key stimulus, io_cycle pattern and run timeout
`timescale 1ns/1ns

module tb_prg_loader
	import c64_loader_pkg::*;
();

	localparam int unsigned STEP = 200;
	localparam int PASS_KEYS = 32;

	logic      clk_sys;
	logic      reset_n;
	logic      ioctl_download_i;
	dl_index_t ioctl_index_i;
	logic      ioctl_wr_i;
	dl_addr_t  ioctl_addr_i;
	byte_t     ioctl_data_i;
	logic      ioctl_wait_o;
	logic      io_cycle_i;
	logic      mem_we_o;
	c64_addr_t mem_addr_o;
	byte_t     mem_data_o;
	ps2_key_t  ps2_key_i;
	ps2_key_t  key_o;
	int        io_phase = 0;
	int        cycle_count = 0;
	int        cycle_limit = 0;
	c64_addr_t load_a;
	c64_addr_t load_b;
	int        len_a;
	int        len_b;
	int        e0;

	tb_clock_gen clk_gen (
		.clk_sys (clk_sys),
		.reset_n (reset_n)
	);

	prg_loader_top #(
		.step_cycles (STEP)
	) uut (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.ioctl_wait_o     (ioctl_wait_o),
		.io_cycle_i       (io_cycle_i),
		.mem_we_o         (mem_we_o),
		.mem_addr_o       (mem_addr_o),
		.mem_data_o       (mem_data_o),
		.ps2_key_i        (ps2_key_i),
		.key_o            (key_o)
	);

	tb_checker chk (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.ioctl_wait_i (ioctl_wait_o),
		.mem_we_i     (mem_we_o),
		.mem_addr_i   (mem_addr_o),
		.mem_data_i   (mem_data_o),
		.key_i        (key_o),
		.ps2_key_i    (ps2_key_i)
	);

	// CPU-free slot pattern of 4 high and 8 low cycles
	always @(negedge clk_sys) begin
		io_phase   <= (io_phase == 11) ? 0 : io_phase + 1;
		io_cycle_i <= (io_phase < 4);
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			chk.print_summary();
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic wait_host_ready();
		while (ioctl_wait_o)
			@(negedge clk_sys);
	endtask

	// ==================================================
	// One PRG download followed by the wait for RUN to be typed
	// ==================================================
	task automatic run_download(input c64_addr_t load, input int len);
		byte_t b;
		chk.begin_download();
		@(negedge clk_sys);
		ioctl_index_i    = PRG_INDEX;
		ioctl_download_i = 1'b1;
		for (int i = 0; i < len + 2; i++) begin
			wait_host_ready();
			b = (i == 0) ? load[7:0] : (i == 1) ? load[15:8] : byte_t'($urandom);
			ioctl_addr_i = dl_addr_t'(i);
			ioctl_data_i = b;
			ioctl_wr_i   = 1'b1;
			chk.note_host_write(i, b);
			@(negedge clk_sys);
			ioctl_wr_i = 1'b0;
			// Busy shows two edges after the strobe
			@(negedge clk_sys);
		end
		wait_host_ready();
		ioctl_download_i = 1'b0;
		while (chk.key_count < 8)
			@(negedge clk_sys);
		// One more step to catch extra key events
		repeat (STEP) @(negedge clk_sys);
	endtask

	initial begin
		ioctl_download_i = 1'b0;
		ioctl_index_i    = '0;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = '0;
		io_cycle_i       = 1'b0;
		ps2_key_i        = '0;
		void'($urandom(32));

		len_a  = 1 + int'($urandom % 40);
		len_b  = 1 + int'($urandom % 40);
		load_a = c64_addr_t'(32'h0200 + ($urandom % 32'hFD00));
		load_b = c64_addr_t'(32'h0200 + ($urandom % 32'hFD00));
		// The second end address must differ from the first
		while (load_b == load_a
			|| load_b + c64_addr_t'(len_b) == load_a + c64_addr_t'(len_a))
			load_b = c64_addr_t'(32'h0200 + ($urandom % 32'hFD00));
		cycle_limit = 2 * ((len_a + len_b + 4) * 4 * 12 + 2 * 256 * 24 + 2 * 9 * STEP
			+ PASS_KEYS + 16);

		@(posedge reset_n);
		repeat (2) @(negedge clk_sys);

		chk.start_passthrough();
		repeat (PASS_KEYS) begin
			@(negedge clk_sys);
			ps2_key_i = ps2_key_t'($urandom);
		end
		repeat (2) @(negedge clk_sys);
		chk.stop_passthrough();
		ps2_key_i = '0;
		repeat (4) @(negedge clk_sys);

		run_download(load_a, len_a);
		chk.check_download("");

		e0 = chk.err_count;
		run_download(load_b, len_b);
		chk.check_download("second_download.");
		chk.close_test("second_download", chk.err_count - e0);

		chk.print_summary();
		if (chk.err_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* tb_checker.sv */
// Reference memory, write and key event logs, comparisons, per-test report and summary
`timescale 1ns/1ns

module tb_checker
	import c64_loader_pkg::*;
(
	input logic      clk_sys,
	input logic      reset_n,
	input logic      ioctl_wait_i,
	input logic      mem_we_i,
	input c64_addr_t mem_addr_i,
	input byte_t     mem_data_i,
	input ps2_key_t  key_i,
	input ps2_key_t  ps2_key_i
);

	// Six two-byte pointers in zero page
	localparam int PTR_BYTES = 12;

	byte_t      ref_mem [0:65535];
	byte_t      dut_mem [0:65535];
	logic [7:0] hits [0:65535];
	ps2_key_t   key_log [0:15];
	c64_addr_t  load_addr = '0;
	int         payload_len = 0;
	int         write_count = 0;
	int         key_count = 0;
	int         pass_compares = 0;
	int         pass_start = 0;
	int         hold_errs = 0;
	int         err_count = 0;
	int         tests_run = 0;
	int         tests_failed = 0;
	logic       key_capture = 1'b0;
	logic       pass_check = 1'b0;
	logic       we_q = 1'b0;
	ps2_key_t   key_q = '0;
	ps2_key_t   ps2_q = '0;

	// ==================================================
	// Bus monitors
	// ==================================================
	always @(posedge clk_sys) begin
		we_q  <= mem_we_i;
		key_q <= key_i;
		ps2_q <= ps2_key_i;
		if (reset_n) begin
			// One write per rising edge of the write enable
			if (mem_we_i && !we_q) begin
				dut_mem[mem_addr_i] = mem_data_i;
				if (hits[mem_addr_i] != 8'hFF)
					hits[mem_addr_i] = hits[mem_addr_i] + 8'd1;
				write_count++;
				// Zero-page writes come from the walk while the host is held
				if (mem_addr_i[15:8] == 8'h00 && ioctl_wait_i !== 1'b1) begin
					hold_errs++;
					err_count++;
					$display("CHECK FAILED walk_hold at %h expected 1 actual %b",
						mem_addr_i, ioctl_wait_i);
				end
			end
			if (key_capture && key_i[KEY_STROBE_BIT] != key_q[KEY_STROBE_BIT]
				&& key_count < 16) begin
				key_log[key_count] = key_i;
				key_count++;
			end
			if (pass_check) begin
				pass_compares++;
				if (key_i !== ps2_q) begin
					err_count++;
					$display("CHECK FAILED key_passthrough expected %h actual %h",
						ps2_q, key_i);
				end
			end
		end
	end

	// ==================================================
	// Model and checks
	// ==================================================
	task automatic close_test(input string name, input int errs);
		tests_run++;
		if (errs == 0) begin
			$display("PASSED %s", name);
		end else begin
			tests_failed++;
			$display("FAILED %s with %0d errors", name, errs);
		end
	endtask

	task automatic begin_download();
		for (int a = 0; a < 65536; a++)
			hits[a] = 8'd0;
		write_count = 0;
		payload_len = 0;
		key_count   = 0;
		hold_errs   = 0;
		key_capture = 1'b1;
	endtask

	// Header bytes give the load address and the rest land behind it
	task automatic note_host_write(input int offset, input byte_t data);
		if (offset == 0) begin
			load_addr[7:0] = data;
		end else if (offset == 1) begin
			load_addr[15:8] = data;
		end else begin
			ref_mem[load_addr + c64_addr_t'(offset - 2)] = data;
			payload_len++;
		end
	endtask

	task automatic check_byte(input string name, input c64_addr_t addr, input byte_t exp);
		if (hits[addr] != 8'd1) begin
			err_count++;
			$display("CHECK FAILED %s writes to %h expected 1 actual %0d", name, addr,
				hits[addr]);
		end else if (dut_mem[addr] !== exp) begin
			err_count++;
			$display("CHECK FAILED %s at %h expected %h actual %h", name, addr, exp,
				dut_mem[addr]);
		end
	endtask

	task automatic check_download(input string prefix);
		int        e0;
		string     nm;
		c64_addr_t end_addr;
		c64_addr_t word;
		byte_t     lo_list [0:5];
		byte_t     codes [0:3];
		logic [9:0] exp_ev;
		key_capture = 1'b0;
		end_addr    = load_addr + c64_addr_t'(payload_len);

		nm = {prefix, "payload_bytes"};
		e0 = err_count;
		for (int i = 0; i < payload_len; i++)
			check_byte(nm, load_addr + c64_addr_t'(i), ref_mem[load_addr + c64_addr_t'(i)]);
		close_test(nm, err_count - e0);

		nm      = {prefix, "basic_pointers"};
		e0      = err_count;
		lo_list = '{PTR_TXT_LO, PTR_SAVE_LO, PTR_VAR, PTR_ARY, PTR_STR, PTR_LOADEND};
		for (int i = 0; i < 6; i++) begin
			if (i == 0)
				word = {TXT_START_HI, TXT_START_LO};
			else if (i == 1)
				word = 16'h0000;
			else
				word = end_addr;
			check_byte(nm, {8'h00, lo_list[i]}, word[7:0]);
			check_byte(nm, {8'h00, lo_list[i] + 8'd1}, word[15:8]);
		end
		close_test(nm, err_count - e0 + hold_errs);

		nm = {prefix, "no_stray_writes"};
		e0 = err_count;
		if (write_count != payload_len + PTR_BYTES) begin
			err_count++;
			$display("CHECK FAILED %s expected %0d actual %0d", nm, payload_len + PTR_BYTES,
				write_count);
		end
		close_test(nm, err_count - e0);

		// Press on even steps and release on odd ones
		nm    = {prefix, "autotype_sequence"};
		e0    = err_count;
		codes = '{KEY_R, KEY_U, KEY_N, KEY_RETURN};
		if (key_count != 8) begin
			err_count++;
			$display("CHECK FAILED %s event count expected 8 actual %0d", nm, key_count);
		end
		for (int i = 0; i < 8 && i < key_count; i++) begin
			exp_ev = {~i[0], 1'b0, codes[i / 2]};
			if (key_log[i][9:0] !== exp_ev) begin
				err_count++;
				$display("CHECK FAILED %s event %0d expected %h actual %h", nm, i, exp_ev,
					key_log[i][9:0]);
			end
		end
		close_test(nm, err_count - e0);
	endtask

	task automatic start_passthrough();
		pass_start    = err_count;
		pass_compares = 0;
		pass_check    = 1'b1;
	endtask

	task automatic stop_passthrough();
		pass_check = 1'b0;
		if (pass_compares == 0) begin
			err_count++;
			$display("Key pass-through was never compared");
		end
		close_test("key_passthrough", err_count - pass_start);
	endtask

	task automatic print_summary();
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, err_count);
	endtask

endmodule

/* tb_clock_gen.sv */
// Testbench clock source with 20 ns period and a three-cycle reset
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_sys,
	output logic reset_n
);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Release on a falling edge, like every other stimulus
	initial begin
		reset_n = 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset_n = 1'b1;
	end

endmodule

/* prg_loader_top.sv */
// PRG injection top level joining parser, pointer walk, memory slot and autotype
`timescale 1ns/1ns

module prg_loader_top
	import c64_loader_pkg::*;
#(
	parameter int unsigned step_cycles = AUTOTYPE_STEP_DEFAULT
)
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      ioctl_download_i,
	input  dl_index_t ioctl_index_i,
	input  logic      ioctl_wr_i,
	input  dl_addr_t  ioctl_addr_i,
	input  byte_t     ioctl_data_i,
	output logic      ioctl_wait_o,
	input  logic      io_cycle_i,
	output logic      mem_we_o,
	output c64_addr_t mem_addr_o,
	output byte_t     mem_data_o,
	input  ps2_key_t  ps2_key_i,
	output ps2_key_t  key_o
);

	// ==================================================
	// Internal connections
	// ==================================================
	logic      req;
	c64_addr_t req_addr;
	byte_t     req_data;
	logic      done;
	c64_addr_t end_addr;
	logic      slot_req;
	c64_addr_t slot_addr;
	byte_t     slot_data;
	logic      slot_busy;
	logic      type_start;

	prg_stream_parser u_parser (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.req_o            (req),
		.req_addr_o       (req_addr),
		.req_data_o       (req_data),
		.done_o           (done),
		.end_addr_o       (end_addr)
	);

	basic_ptr_init u_ptr_init (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.req_i        (req),
		.done_i       (done),
		.req_addr_i   (req_addr),
		.end_addr_i   (end_addr),
		.req_data_i   (req_data),
		.busy_i       (slot_busy),
		.slot_req_o   (slot_req),
		.slot_addr_o  (slot_addr),
		.slot_data_o  (slot_data),
		.ioctl_wait_o (ioctl_wait_o),
		.start_o      (type_start)
	);

	mem_write_slot u_slot (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.req_i      (slot_req),
		.addr_i     (slot_addr),
		.data_i     (slot_data),
		.io_cycle_i (io_cycle_i),
		.busy_o     (slot_busy),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

	key_autotype #(
		.step_cycles (step_cycles)
	) u_autotype (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.start_i   (type_start),
		.ps2_key_i (ps2_key_i),
		.key_o     (key_o)
	);

endmodule

/* key_autotype.sv */
// Keyboard pass-through with RUN RETURN playback after pointer injection
`timescale 1ns/1ns

module key_autotype
	import c64_loader_pkg::*;
#(
	parameter int unsigned step_cycles = AUTOTYPE_STEP_DEFAULT
)
(
	input  logic     clk_sys,
	input  logic     reset_n,
	input  logic     start_i,
	input  ps2_key_t ps2_key_i,
	output ps2_key_t key_o
);

	type_state_t state;
	logic [31:0] step_cnt;
	logic [2:0]  step_idx;
	byte_t       step_code;

	// Two steps per key, press then release
	always_comb begin
		case (step_idx[2:1])
			2'd0:    step_code = KEY_R;
			2'd1:    step_code = KEY_U;
			2'd2:    step_code = KEY_N;
			default: step_code = KEY_RETURN;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state    <= TYPE_PASS;
			step_cnt <= '0;
			step_idx <= '0;
			key_o    <= '0;
		end else if (state == TYPE_PASS) begin
			key_o    <= ps2_key_i;
			step_cnt <= '0;
			step_idx <= '0;
			if (start_i) begin
				state <= TYPE_PLAY;
			end
		end else begin
			step_cnt <= step_cnt + 32'd1;
			if (step_cnt == step_cycles - 1) begin
				step_cnt                <= '0;
				step_idx                <= step_idx + 3'd1;
				key_o[7:0]              <= step_code;
				key_o[KEY_PRESS_BIT]    <= ~step_idx[0];
				key_o[KEY_STROBE_BIT]   <= ~key_o[KEY_STROBE_BIT];
				// Eight toggles leave the strobe where pass-through had it
				if (step_idx == 3'd7) begin
					state <= TYPE_PASS;
				end
			end
		end
	end

	// Walk ends at most once per download, never during playback
	start_in_pass: assert property (@(posedge clk_sys) disable iff (!reset_n)
		start_i |-> (state == TYPE_PASS))
		else $error("autotype restarted during playback");

endmodule

/* mem_write_slot.sv */
// Single-entry write buffer that places each write into the CPU-free memory slot
`timescale 1ns/1ns

module mem_write_slot
	import c64_loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      req_i,
	input  c64_addr_t addr_i,
	input  byte_t     data_i,
	input  logic      io_cycle_i,
	output logic      busy_o,
	output logic      mem_we_o,
	output c64_addr_t mem_addr_o,
	output byte_t     mem_data_o
);

	logic      pending;
	logic      io_cycle_d;
	c64_addr_t pend_addr;
	byte_t     pend_data;

	assign busy_o = pending;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			pending    <= 1'b0;
			io_cycle_d <= 1'b0;
			pend_addr  <= '0;
			pend_data  <= '0;
			mem_we_o   <= 1'b0;
			mem_addr_o <= '0;
			mem_data_o <= '0;
		end else begin
			io_cycle_d <= io_cycle_i;

			if (req_i) begin
				pending   <= 1'b1;
				pend_addr <= addr_i;
				pend_data <= data_i;
			end

			// Slot opens on the falling edge of io_cycle
			if (~io_cycle_i & io_cycle_d & pending) begin
				pending    <= 1'b0;
				mem_we_o   <= 1'b1;
				mem_addr_o <= pend_addr;
				mem_data_o <= pend_data;
			end

			// Second high sample closes the slot
			if (io_cycle_i & io_cycle_d) begin
				mem_we_o <= 1'b0;
			end
		end
	end

	// Upstream must hold off while a write is still pending
	no_overrun: assert property (@(posedge clk_sys) disable iff (!reset_n)
		req_i |-> !busy_o)
		else $error("write request arrived while slot was busy");

endmodule

/* basic_ptr_init.sv */
// BASIC zero-page pointer walk, shared write request port and download hold
`timescale 1ns/1ns

module basic_ptr_init
	import c64_loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      req_i,
	input  logic      done_i,
	input  c64_addr_t req_addr_i,
	input  c64_addr_t end_addr_i,
	input  byte_t     req_data_i,
	input  logic      busy_i,
	output logic      slot_req_o,
	output c64_addr_t slot_addr_o,
	output byte_t     slot_data_o,
	output logic      ioctl_wait_o,
	output logic      start_o
);

	ptr_state_t state;
	zp_addr_t   zp;
	c64_addr_t  end_q;
	logic       walk_req;
	logic       ptr_hit;
	byte_t      ptr_byte;

	// Values a LOAD command leaves in the pointers
	always_comb begin
		ptr_hit  = 1'b1;
		ptr_byte = 8'h00;
		case (zp[7:0])
			PTR_TXT_LO: ptr_byte = TXT_START_LO;
			PTR_TXT_HI: ptr_byte = TXT_START_HI;
			PTR_SAVE_LO, PTR_SAVE_HI: ptr_byte = 8'h00;
			PTR_VAR, PTR_ARY, PTR_STR, PTR_LOADEND: ptr_byte = end_q[7:0];
			PTR_VAR + 8'd1, PTR_ARY + 8'd1, PTR_STR + 8'd1, PTR_LOADEND + 8'd1:
				ptr_byte = end_q[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	// Idle forwards payload requests, walk drives zero-page writes
	assign slot_req_o   = (state == PTR_WALK) ? walk_req : req_i;
	assign slot_addr_o  = (state == PTR_WALK) ? {8'h00, zp[7:0]} : req_addr_i;
	assign slot_data_o  = (state == PTR_WALK) ? ptr_byte : req_data_i;
	assign ioctl_wait_o = (state == PTR_WALK) | busy_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state    <= PTR_IDLE;
			zp       <= '0;
			end_q    <= '0;
			walk_req <= 1'b0;
			start_o  <= 1'b0;
		end else begin
			start_o <= 1'b0;
			case (state)
				PTR_IDLE: begin
					if (done_i) begin
						state <= PTR_WALK;
						zp    <= '0;
						end_q <= end_addr_i;
					end
				end
				PTR_WALK: begin
					// Request goes out this cycle, then wait for the slot to drain
					if (walk_req) begin
						walk_req <= 1'b0;
						zp       <= zp + zp_addr_t'(1);
					end else if (!busy_i) begin
						if (zp == ZP_END) begin
							state   <= PTR_IDLE;
							start_o <= 1'b1;
						end else if (ptr_hit) begin
							walk_req <= 1'b1;
						end else begin
							zp <= zp + zp_addr_t'(1);
						end
					end
				end
				default: state <= PTR_IDLE;
			endcase
		end
	end

	walk_bound: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(state == PTR_WALK) |-> (zp <= ZP_END))
		else $error("zero-page walker passed its end");

endmodule

/* prg_stream_parser.sv */
// PRG stream parser with load address capture, payload write requests and end-of-download pulse
`timescale 1ns/1ns

module prg_stream_parser
	import c64_loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      ioctl_download_i,
	input  logic      ioctl_wr_i,
	input  dl_index_t ioctl_index_i,
	input  dl_addr_t  ioctl_addr_i,
	input  byte_t     ioctl_data_i,
	output logic      req_o,
	output c64_addr_t req_addr_o,
	output byte_t     req_data_o,
	output logic      done_o,
	output c64_addr_t end_addr_o
);

	logic      load_prg;
	logic      old_download;
	c64_addr_t load_addr;

	assign load_prg = (ioctl_index_i == PRG_INDEX);

	// After the last payload byte the running address is load + count
	assign end_addr_o = load_addr;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			old_download <= 1'b0;
			load_addr    <= '0;
			req_o        <= 1'b0;
			req_addr_o   <= '0;
			req_data_o   <= '0;
			done_o       <= 1'b0;
		end else begin
			old_download <= ioctl_download_i;
			req_o        <= 1'b0;
			done_o       <= old_download & ~ioctl_download_i & load_prg;

			if (ioctl_wr_i && load_prg) begin
				// Two-byte header, low byte first
				if (ioctl_addr_i == dl_addr_t'(0)) begin
					load_addr[7:0] <= ioctl_data_i;
				end else if (ioctl_addr_i == dl_addr_t'(1)) begin
					load_addr[15:8] <= ioctl_data_i;
				end else begin
					req_o      <= 1'b1;
					req_addr_o <= load_addr;
					req_data_o <= ioctl_data_i;
					load_addr  <= load_addr + c64_addr_t'(1);
				end
			end
		end
	end

endmodule

/* c64_loader_pkg.sv */
// Shared types, download index, BASIC pointer map, PS/2 scan codes and timing constants
package c64_loader_pkg;

	// ==================================================
	// Types
	// ==================================================
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] c64_addr_t;
	typedef logic [15:0] dl_addr_t;
	typedef logic [7:0]  dl_index_t;
	typedef logic [10:0] ps2_key_t;
	// One bit wider than zero page so the walk can reach its end value
	typedef logic [8:0]  zp_addr_t;

	typedef enum logic {PTR_IDLE, PTR_WALK} ptr_state_t;
	typedef enum logic {TYPE_PASS, TYPE_PLAY} type_state_t;

	// ==================================================
	// Download and zero-page map
	// ==================================================
	localparam dl_index_t PRG_INDEX = 8'd4;
	localparam zp_addr_t  ZP_END    = 9'd256;

	// TXT start as left by a cold reset
	localparam byte_t TXT_START_LO = 8'h01;
	localparam byte_t TXT_START_HI = 8'h08;

	localparam byte_t PTR_TXT_LO  = 8'h2B;
	localparam byte_t PTR_TXT_HI  = 8'h2C;
	localparam byte_t PTR_SAVE_LO = 8'hAC;
	localparam byte_t PTR_SAVE_HI = 8'hAD;
	// Low bytes of the pointers set to the load end, high byte follows each
	localparam byte_t PTR_VAR     = 8'h2D;
	localparam byte_t PTR_ARY     = 8'h2F;
	localparam byte_t PTR_STR     = 8'h31;
	localparam byte_t PTR_LOADEND = 8'hAE;

	// ==================================================
	// Keyboard
	// ==================================================
	localparam byte_t KEY_R      = 8'h2D;
	localparam byte_t KEY_U      = 8'h3C;
	localparam byte_t KEY_N      = 8'h31;
	localparam byte_t KEY_RETURN = 8'h5A;

	localparam int KEY_PRESS_BIT  = 9;
	localparam int KEY_STROBE_BIT = 10;

	localparam int unsigned AUTOTYPE_STEP_DEFAULT = 1280000;

endpackage
